//--- fetchBpu.f
+incdir+tb
verilog/pipePkg.sv
verilog/bpuPkg.sv
verilog/simplePortRam.sv
verilog/returnStack.sv
verilog/branchPredictor.sv
verilog/pcSelect.sv
verilog/fetchFrontEnd.sv
tb/fetchFrontEnd_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f fetchBpu.f --top-module fetchFrontEnd_tb -o simFetch \
    || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/simFetch)"
echo "$simOut"

echo "$simOut" | grep -q "^RESULT: PASS$" && exit 0 || exit 1

//--- tb/stimTable.svh
`ifndef STIM_TABLE_SVH
`define STIM_TABLE_SVH

// one row per cycle
// ctl is {stall, flush}, expVt is {valid, taken}
typedef struct packed {
    int         group;
    logic [1:0] ctl;
    addrT       redirect;
    resolveT    res;
    addrT       expPc;
    logic [1:0] expVt;
    branchKind  expKind;
    addrT       expTarget;
} stimRow;

localparam int numRows = 35;

stimRow rows [numRows];

function automatic resolveT res(input addrT pc, input branchKind kind, input logic taken,
                                input addrT target, input logic hit, input logic [1:0] count,
                                input logic [7:0] index);
    resolveT r;
    r.valid  = 1'b1;
    r.pc     = pc;
    r.kind   = kind;
    r.taken  = taken;
    r.target = target;
    r.hit    = hit;
    r.count  = count;
    r.index  = index;
    return r;
endfunction

function automatic stimRow mkRow(input int group, input logic [1:0] ctl, input addrT redirect,
                                 input resolveT r, input addrT expPc, input logic [1:0] expVt,
                                 input branchKind expKind, input addrT expTarget);
    stimRow s;
    s.group     = group;
    s.ctl       = ctl;
    s.redirect  = redirect;
    s.res       = r;
    s.expPc     = expPc;
    s.expVt     = expVt;
    s.expKind   = expKind;
    s.expTarget = expTarget;
    return s;
endfunction

task automatic fillTable;
    resolveT none;
    resolveT jmp;
    resolveT brTaken;
    resolveT brNot1;
    resolveT brNot2;
    resolveT ret;
    resolveT call1;
    resolveT call2;
    none    = '0;
    jmp     = res(32'h100, kindJump, 1'b1, 32'h400, 1'b0, 2'd0, 8'd0);
    brTaken = res(32'h520, kindBranch, 1'b1, 32'h600, 1'b0, 2'd0, 8'd3);  // history after it is 3
    brNot1  = res(32'h520, kindBranch, 1'b0, 32'h600, 1'b1, 2'd2, 8'd3);
    brNot2  = res(32'h520, kindBranch, 1'b0, 32'h600, 1'b1, 2'd0, 8'd6);
    ret     = res(32'h840, kindReturn, 1'b1, 32'h0, 1'b0, 2'd0, 8'd0);
    call1   = res(32'h744, kindCall, 1'b1, 32'h800, 1'b0, 2'd0, 8'd0);
    call2   = res(32'h748, kindCall, 1'b1, 32'h800, 1'b0, 2'd0, 8'd0);
    // sequential after reset, all misses
    rows[0]  = mkRow(1, 2'b00, 32'h0,   none,    32'h000, 2'b00, kindNone,   32'h000);
    rows[1]  = mkRow(1, 2'b00, 32'h0,   none,    32'h004, 2'b10, kindNone,   32'h00C);
    rows[2]  = mkRow(1, 2'b00, 32'h0,   none,    32'h008, 2'b10, kindNone,   32'h010);
    rows[3]  = mkRow(1, 2'b00, 32'h0,   none,    32'h00C, 2'b10, kindNone,   32'h014);
    // jump at 0x100, reached by flushing just below it
    rows[4]  = mkRow(2, 2'b00, 32'h0,   jmp,     32'h010, 2'b10, kindNone,   32'h018);
    rows[5]  = mkRow(2, 2'b01, 32'hF8,  none,    32'h014, 2'b10, kindNone,   32'h01C);
    rows[6]  = mkRow(2, 2'b00, 32'h0,   none,    32'h0F8, 2'b00, kindNone,   32'h000);
    rows[7]  = mkRow(2, 2'b00, 32'h0,   none,    32'h0FC, 2'b10, kindNone,   32'h104);
    rows[8]  = mkRow(2, 2'b00, 32'h0,   none,    32'h100, 2'b11, kindJump,   32'h400);
    rows[9]  = mkRow(2, 2'b00, 32'h0,   none,    32'h400, 2'b00, kindNone,   32'h408);
    rows[10] = mkRow(2, 2'b00, 32'h0,   none,    32'h404, 2'b10, kindNone,   32'h40C);
    // branch at 0x520, counter 2 then stepped down
    rows[11] = mkRow(3, 2'b00, 32'h0,   brTaken, 32'h408, 2'b10, kindNone,   32'h410);
    rows[12] = mkRow(3, 2'b01, 32'h51C, none,    32'h40C, 2'b10, kindNone,   32'h414);
    rows[13] = mkRow(3, 2'b00, 32'h0,   none,    32'h51C, 2'b00, kindNone,   32'h000);
    rows[14] = mkRow(3, 2'b00, 32'h0,   brNot1,  32'h520, 2'b11, kindBranch, 32'h600);
    rows[15] = mkRow(3, 2'b01, 32'h51C, none,    32'h600, 2'b00, kindNone,   32'h608);
    rows[16] = mkRow(3, 2'b00, 32'h0,   none,    32'h51C, 2'b00, kindNone,   32'h000);
    rows[17] = mkRow(3, 2'b00, 32'h0,   brNot2,  32'h520, 2'b10, kindBranch, 32'h528);
    // return at 0x840, calls at 0x744 and 0x748
    rows[18] = mkRow(4, 2'b00, 32'h0,   ret,     32'h524, 2'b10, kindNone,   32'h52C);
    rows[19] = mkRow(4, 2'b01, 32'h83C, call1,   32'h528, 2'b10, kindNone,   32'h530);
    rows[20] = mkRow(4, 2'b00, 32'h0,   call2,   32'h83C, 2'b00, kindNone,   32'h000);
    rows[21] = mkRow(4, 2'b00, 32'h0,   ret,     32'h840, 2'b11, kindReturn, 32'h750);
    rows[22] = mkRow(4, 2'b01, 32'h83C, none,    32'h750, 2'b00, kindNone,   32'h758);
    rows[23] = mkRow(4, 2'b00, 32'h0,   none,    32'h83C, 2'b00, kindNone,   32'h000);
    rows[24] = mkRow(4, 2'b00, 32'h0,   none,    32'h840, 2'b11, kindReturn, 32'h74C);
    rows[25] = mkRow(4, 2'b00, 32'h0,   none,    32'h74C, 2'b00, kindNone,   32'h754);
    // stall holds, flush beats stall and a taken jump
    rows[26] = mkRow(5, 2'b10, 32'h0,   none,    32'h750, 2'b10, kindNone,   32'h758);
    rows[27] = mkRow(5, 2'b10, 32'h0,   none,    32'h750, 2'b10, kindNone,   32'h758);
    rows[28] = mkRow(5, 2'b00, 32'h0,   none,    32'h750, 2'b10, kindNone,   32'h758);
    rows[29] = mkRow(5, 2'b01, 32'hFC,  none,    32'h754, 2'b10, kindNone,   32'h75C);
    rows[30] = mkRow(5, 2'b00, 32'h0,   none,    32'h0FC, 2'b00, kindNone,   32'h000);
    rows[31] = mkRow(5, 2'b10, 32'h0,   none,    32'h100, 2'b11, kindJump,   32'h400);
    rows[32] = mkRow(5, 2'b11, 32'h200, none,    32'h100, 2'b11, kindJump,   32'h400);
    rows[33] = mkRow(5, 2'b00, 32'h0,   none,    32'h200, 2'b00, kindNone,   32'h000);
    rows[34] = mkRow(5, 2'b00, 32'h0,   none,    32'h204, 2'b10, kindNone,   32'h20C);
endtask

`endif

//--- tb/fetchFrontEnd_tb.sv
`timescale 1ns/10ps

module fetchFrontEnd_tb import pipePkg::*, bpuPkg::*; ();

    localparam int resetCycles = 8;
    localparam int randCount   = 6;
    localparam int randCycles  = 4 * randCount;   // resolve plus three per lookup

    logic    clk;
    logic    reset;
    logic    stall;
    logic    flush;
    addrT    redirectPc;
    resolveT resolve;
    addrT    fetchPc;
    predictT prediction;

    int          passCount;
    int          failCount;
    int          groupErrors;
    int          cycleCount;
    logic [31:0] rngState;

    // small model of what the random resolves wrote
    addrT      randPc [randCount];
    addrT      randTarget [randCount];
    branchKind randKind [randCount];

    `include "stimTable.svh"

    localparam int cycleLimit = 2 * (numRows + randCycles) + resetCycles;

    fetchFrontEnd i_dut (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .redirectPc (redirectPc),
        .resolve    (resolve),
        .fetchPc    (fetchPc),
        .prediction (prediction)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("run stopped, cycle limit %0d reached before the tests finished", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            failCount++;
            groupErrors++;
        end else begin
            passCount++;
        end
    endtask

    // inputs change shortly after the rising edge
    task automatic driveCycle(input logic st, input logic fl, input addrT redir,
                              input resolveT r);
        @(posedge clk);
        #2;
        stall      = st;
        flush      = fl;
        redirectPc = redir;
        resolve    = r;
    endtask

    task automatic checkOutputs(input addrT expPc, input logic [1:0] expVt,
                                input branchKind expKind, input addrT expTarget);
        @(negedge clk);   // registered outputs settled mid cycle
        check("fetchPc", fetchPc, expPc);
        check("prediction.valid", {31'd0, prediction.valid}, {31'd0, expVt[1]});
        check("prediction.taken", {31'd0, prediction.taken}, {31'd0, expVt[0]});
        check("prediction.kind", {29'd0, prediction.kind}, {29'd0, expKind});
        check("prediction.hit", {31'd0, prediction.hit},
              {31'd0, expKind != kindNone});   // a miss reports kind none
        check("prediction.target", prediction.target, expTarget);
    endtask

    task automatic reportGroup(input int group);
        $display("group %0d finished with %0d errors", group, groupErrors);
        groupErrors = 0;
    endtask

    task automatic runTable;
        for (int i = 0; i < numRows; i++) begin
            driveCycle(rows[i].ctl[1], rows[i].ctl[0], rows[i].redirect, rows[i].res);
            if (i == 0) begin
                reset = 1'b0;
            end
            checkOutputs(rows[i].expPc, rows[i].expVt, rows[i].expKind, rows[i].expTarget);
            // resolve fed back from this prediction carries its counter and history
            if (rows[i].res.valid && rows[i].res.hit) begin
                check("prediction.count", {30'd0, prediction.count},
                      {30'd0, rows[i].res.count});
                check("prediction.index", {24'd0, prediction.index},
                      {24'd0, rows[i].res.index});
            end
            if (i == numRows - 1 || rows[i + 1].group != rows[i].group) begin
                reportGroup(rows[i].group);
            end
        end
    endtask

    task automatic runRandomGroup;
        logic [btbIndexBits-1:0] set;
        for (int i = 0; i < randCount; i++) begin
            rngState = xorshift(rngState);
            set = {1'b1, 4'(i), rngState[0]};   // distinct sets in the upper half
            randPc[i] = {rngState[31:8], set, 2'b00};
            rngState = xorshift(rngState);
            randTarget[i] = {rngState[31:2], 2'b00};
            randKind[i] = rngState[2] ? kindCall : kindJump;
            driveCycle(1'b0, 1'b0, 32'h0,
                       res(randPc[i], randKind[i], 1'b1, randTarget[i], 1'b0, 2'd0, 8'd0));
        end
        for (int i = 0; i < randCount; i++) begin
            driveCycle(1'b0, 1'b1, randPc[i] - 32'd4, '0);
            driveCycle(1'b0, 1'b0, 32'h0, '0);   // flushed slot, pc - 4
            driveCycle(1'b0, 1'b0, 32'h0, '0);
            checkOutputs(randPc[i], 2'b11, randKind[i], randTarget[i]);
        end
        reportGroup(6);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        redirectPc  = '0;
        resolve     = '0;
        passCount   = 0;
        failCount   = 0;
        groupErrors = 0;
        cycleCount  = 0;
        rngState    = 32'd45267;
        fillTable();
        repeat (resetCycles - 1) @(posedge clk);
        runTable();
        runRandomGroup();
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/fetchFrontEnd.sv
`timescale 1ns/10ps

module fetchFrontEnd import pipePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  addrT    redirectPc,
    input  resolveT resolve,
    output addrT    fetchPc,
    output predictT prediction
);

    addrT lookupPc;   // pc chosen this cycle, feeds the table lookup

    pcSelect pcSel (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .redirectPc (redirectPc),
        .prediction (prediction),
        .lookupPc   (lookupPc),
        .fetchPc    (fetchPc)
    );

    branchPredictor bpu (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .lookupPc   (lookupPc),
        .resolve    (resolve),
        .prediction (prediction)
    );

endmodule

//--- verilog/pcSelect.sv
`timescale 1ns/10ps

module pcSelect import pipePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  addrT    redirectPc,
    input  predictT prediction,
    output addrT    lookupPc,
    output addrT    fetchPc
);

    logic predTaken;

    // a prediction counts only while its register slot is valid
    assign predTaken = prediction.valid && prediction.taken;

    // next pc, flush beats stall beats prediction
    always_comb begin
        if (flush) begin
            lookupPc = redirectPc;
        end else if (stall) begin
            lookupPc = fetchPc;
        end else if (predTaken) begin
            lookupPc = prediction.target;
        end else begin
            lookupPc = fetchPc + 32'd4;
        end
    end

    // lookupPc already equals fetchPc under a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= '0;
        end else begin
            fetchPc <= lookupPc;
        end
    end

endmodule

//--- verilog/branchPredictor.sv
`timescale 1ns/10ps

module branchPredictor import pipePkg::*, bpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  addrT    lookupPc,
    input  resolveT resolve,
    output predictT prediction
);

    logic [historyBits-1:0]  history;
    logic [btbIndexBits-1:0] lookupSet;
    logic [btbIndexBits-1:0] resolveSet;
    logic [phtIndexBits-1:0] phtReadAddr;
    logic [phtIndexBits-1:0] phtWriteAddr;

    btbEntryT btbRead;
    btbEntryT btbWrite;
    ctrT      ctrRead;
    ctrT      ctrWrite;
    rasEntryT rasTop;
    predRegT  predReg;
    logic     hit;
    logic     rasPush;
    logic     rasPop;

    assign lookupSet    = lookupPc[btbIndexBits+1:2];
    assign resolveSet   = resolve.pc[btbIndexBits+1:2];
    assign phtReadAddr  = {history, lookupSet};
    assign phtWriteAddr = {resolve.index, resolveSet};   // history seen at lookup

    // every resolved instruction refreshes its target entry
    always_comb begin
        btbWrite.valid  = 1'b1;
        btbWrite.tag    = resolve.pc[31:btbIndexBits+2];
        btbWrite.kind   = resolve.kind;
        btbWrite.target = resolve.target;
    end

    simplePortRam #(
        .depth    (btbDepth),
        .payloadT (btbEntryT)
    ) btbRam (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (resolve.valid),
        .writeAddr (resolveSet),
        .writeData (btbWrite),
        .readAddr  (lookupSet),
        .readData  (btbRead)
    );

    // two-bit counter step, saturating at both ends
    always_comb begin
        if (resolve.hit) begin
            if (resolve.taken) begin
                ctrWrite = (resolve.count == ctrStrongTaken) ? ctrStrongTaken
                                                             : resolve.count + 2'd1;
            end else begin
                ctrWrite = (resolve.count == ctrStrongNot) ? ctrStrongNot
                                                           : resolve.count - 2'd1;
            end
        end else begin
            // first sighting starts weak in the resolved direction
            ctrWrite = resolve.taken ? ctrWeakTaken : ctrWeakNot;
        end
    end

    simplePortRam #(
        .depth    (phtDepth),
        .payloadT (ctrT)
    ) phtRam (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (resolve.valid),
        .writeAddr (phtWriteAddr),
        .writeData (ctrWrite),
        .readAddr  (phtReadAddr),
        .readData  (ctrRead)
    );

    assign rasPush = resolve.valid && (resolve.kind == kindCall);
    assign rasPop  = resolve.valid && (resolve.kind == kindReturn);

    returnStack ras (
        .clk      (clk),
        .reset    (reset),
        .push     (rasPush),
        .pop      (rasPop),
        .pushAddr (resolve.pc + 32'd8),   // return lands past the delay slot
        .top      (rasTop)
    );

    // lookup results line up with fetchPc one cycle later
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            predReg <= '0;
        end else if (!stall) begin
            predReg.tag        <= btbRead.tag;
            predReg.pcTag      <= lookupPc[31:btbIndexBits+2];
            predReg.entryValid <= btbRead.valid;
            predReg.kind       <= btbRead.kind;
            predReg.btbTarget  <= btbRead.target;
            predReg.ras        <= rasTop;
            predReg.pcPlus8    <= lookupPc + 32'd8;
            predReg.count      <= ctrRead;
            predReg.index      <= history;
            predReg.valid      <= ~prediction.taken;   // instr after a redirect is dropped
        end
    end

    assign hit = predReg.entryValid && (predReg.tag == predReg.pcTag);

    // direction and target from the registered lookup
    always_comb begin
        prediction.valid  = predReg.valid;
        prediction.hit    = hit;
        prediction.kind   = kindNone;
        prediction.taken  = 1'b0;
        prediction.target = predReg.pcPlus8;
        prediction.count  = predReg.count;
        prediction.index  = predReg.index;
        if (hit) begin
            prediction.kind = predReg.kind;
            case (predReg.kind)
                kindCall, kindJump: begin
                    prediction.taken  = 1'b1;
                    prediction.target = predReg.btbTarget;
                end
                kindReturn: begin
                    prediction.taken = 1'b1;
                    if (predReg.ras.valid) begin
                        prediction.target = predReg.ras.addr;
                    end
                end
                kindBranch: begin
                    if (predReg.count[1]) begin   // upper half means taken
                        prediction.taken  = 1'b1;
                        prediction.target = predReg.btbTarget;
                    end
                end
                default: begin
                    prediction.taken = 1'b0;
                end
            endcase
        end
    end

    // global history, only branches and jumps shift in
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (resolve.valid &&
                     (resolve.kind == kindBranch || resolve.kind == kindJump)) begin
            history <= {history[historyBits-2:0], resolve.taken};
        end
    end

endmodule

//--- verilog/returnStack.sv
`timescale 1ns/10ps

module returnStack import pipePkg::*, bpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  addrT     pushAddr,
    output rasEntryT top
);

    rasEntryT              stack [rasDepth];
    logic [rasPtrBits-1:0] ptr;      // next free slot
    logic [rasPtrBits-1:0] below;    // current top slot

    assign below = ptr - 1'b1;       // wraps with the pointer

    // circular, so overflow just overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (reset) begin
            stack <= '{default: '0};
            ptr   <= '0;
        end else if (push) begin
            stack[ptr].valid <= 1'b1;
            stack[ptr].addr  <= pushAddr;
            ptr              <= ptr + 1'b1;
        end else if (pop) begin
            ptr <= below;
        end
    end

    // call resolving this cycle is visible to the lookup right away
    always_comb begin
        if (push) begin
            top.valid = 1'b1;
            top.addr  = pushAddr;
        end else begin
            top = stack[below];
        end
    end

endmodule

//--- verilog/simplePortRam.sv
`timescale 1ns/10ps

// small table, one write and one combinational read per cycle
module simplePortRam #(
    parameter int  depth    = 64,
    parameter type payloadT = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     writeEn,
    input  logic [$clog2(depth)-1:0] writeAddr,
    input  payloadT                  writeData,
    input  logic [$clog2(depth)-1:0] readAddr,
    output payloadT                  readData
);

    payloadT mem [depth];

    // tables start empty so stale entries never hit
    always_ff @(posedge clk) begin
        if (reset) begin
            mem <= '{default: '0};
        end else if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read is async, a write lands after the edge
    assign readData = mem[readAddr];

endmodule

//--- verilog/bpuPkg.sv
package bpuPkg;

    import pipePkg::*;

    // target buffer geometry, indexed by pc[7:2]
    localparam int btbIndexBits = 6;
    localparam int btbDepth     = 1 << btbIndexBits;
    localparam int tagBits      = 32 - btbIndexBits - 2;

    // global history doubles as the upper pattern table index
    localparam int historyBits  = indexBits;
    localparam int phtIndexBits = historyBits + btbIndexBits;
    localparam int phtDepth     = 1 << phtIndexBits;

    localparam int rasDepth     = 8;
    localparam int rasPtrBits   = $clog2(rasDepth);

    typedef logic [1:0] ctrT;

    localparam ctrT ctrStrongNot   = 2'd0;
    localparam ctrT ctrWeakNot     = 2'd1;
    localparam ctrT ctrWeakTaken   = 2'd2;
    localparam ctrT ctrStrongTaken = 2'd3;

    typedef struct packed {
        logic               valid;
        logic [tagBits-1:0] tag;     // pc[31:8]
        branchKind          kind;
        addrT               target;
    } btbEntryT;

    typedef struct packed {
        logic valid;
        addrT addr;
    } rasEntryT;

    // everything the lookup captures for the fetch-stage decision
    typedef struct packed {
        logic [tagBits-1:0]     tag;
        logic [tagBits-1:0]     pcTag;
        logic                   entryValid;
        branchKind              kind;
        addrT                   btbTarget;
        rasEntryT               ras;
        addrT                   pcPlus8;
        ctrT                    count;
        logic [historyBits-1:0] index;
        logic                   valid;
    } predRegT;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

    // width of the history snapshot carried with each prediction
    localparam int indexBits = 8;

    typedef logic [31:0] addrT;

    typedef enum logic [2:0] {
        kindNone   = 3'd0,
        kindBranch = 3'd1,  // conditional, direction from the counter
        kindJump   = 3'd2,
        kindCall   = 3'd3,  // pushes return address
        kindReturn = 3'd4   // target from the return stack
    } branchKind;

    // prediction handed to fetch, travels down the pipe with the instruction
    typedef struct packed {
        logic                 valid;
        logic                 hit;
        logic                 taken;
        branchKind            kind;
        addrT                 target;
        logic [1:0]           count;   // counter value seen at lookup
        logic [indexBits-1:0] index;   // history used at lookup
    } predictT;

    // outcome sent back from execute
    typedef struct packed {
        logic                 valid;
        addrT                 pc;
        branchKind            kind;
        logic                 taken;
        addrT                 target;
        logic                 hit;     // copied from the prediction
        logic [1:0]           count;   // copied from the prediction
        logic [indexBits-1:0] index;   // copied from the prediction
    } resolveT;

endpackage
